//--- rtl/bpf_defs.svh
`ifndef BPF_DEFS_SVH
`define BPF_DEFS_SVH

// Instruction memory address width, in 64-bit words
`define BPF_CODE_ADDR_W 10

// Packet memory byte address width
`define BPF_BYTE_ADDR_W 12

// Packet length as reported by the packet engine
`define BPF_PLEN_W 32

// Instruction word layout
// opcode [63:48], jt [47:40], jf [39:32], k [31:0]
`define BPF_INSTR_W 64

// Scratch memory words, M[0] to M[15]
`define BPF_SCRATCH_N 16

`endif

//--- rtl/bpf_pkg.sv
`default_nettype none

package bpf_pkg;

    // Instruction class, opcode bits 2:0
    typedef enum logic [2:0] {
        CLS_LD   = 3'h0,
        CLS_LDX  = 3'h1,
        CLS_ST   = 3'h2,
        CLS_STX  = 3'h3,
        CLS_ALU  = 3'h4,
        CLS_JMP  = 3'h5,
        CLS_RET  = 3'h6,
        CLS_MISC = 3'h7
    } bpf_class_e;

    // Load size, opcode bits 4:3, also the packet port transfer size
    typedef enum logic [1:0] {
        SZ_W = 2'h0,
        SZ_H = 2'h1,
        SZ_B = 2'h2
    } bpf_size_e;

    // ALU operation, opcode bits 7:4
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_OR  = 4'h4,
        ALU_AND = 4'h5,
        ALU_LSH = 4'h6,
        ALU_RSH = 4'h7
    } bpf_alu_e;

    // Jump condition, opcode bits 6:4
    typedef enum logic [2:0] {
        JMP_JA   = 3'h0,
        JMP_JEQ  = 3'h1,
        JMP_JGT  = 3'h2,
        JMP_JGE  = 3'h3,
        JMP_JSET = 3'h4
    } bpf_jmp_e;

    typedef enum logic [4:0] {
        OP_LD_IMM, OP_LD_ABS, OP_LD_IND, OP_LD_LEN, OP_LD_MEM,
        OP_LDX_IMM, OP_LDX_LEN, OP_LDX_MEM,
        OP_ST, OP_STX, OP_ALU, OP_JA, OP_JCOND,
        OP_RET_K, OP_RET_A, OP_TAX, OP_TXA, OP_ILLEGAL
    } bpf_op_e;

    // Start/done handshake state
    typedef enum logic {
        STOPPED = 1'b0,
        STARTED = 1'b1
    } bpf_run_e;

endpackage

`default_nettype wire

//--- rtl/bpf_fetch.sv
`default_nettype none
`include "bpf_defs.svh"

module bpf_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [`BPF_CODE_ADDR_W-1:0] redirect_pc,
    output logic [`BPF_CODE_ADDR_W-1:0] inst_rd_addr,
    output logic                        inst_rd_en,
    output logic                        fetch_vld,
    output logic [`BPF_CODE_ADDR_W-1:0] fetch_pc
);

    // Next address to read
    logic [`BPF_CODE_ADDR_W-1:0] pc;

    // While stalled, re-read the word decode is waiting on
    assign inst_rd_addr = stall ? fetch_pc : pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_rd_en <= 1'b0;
        end else begin
            inst_rd_en <= 1'b1;
        end
    end

    // fetch_pc and fetch_vld describe the word now on instr_in
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            fetch_pc  <= '0;
            fetch_vld <= 1'b0;
        end else if (redirect) begin
            // Word already in flight is from the wrong path
            pc        <= redirect_pc;
            fetch_vld <= 1'b0;
        end else if (!stall && inst_rd_en) begin
            fetch_pc  <= pc;
            fetch_vld <= 1'b1;
            pc        <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpf_decode.sv
`default_nettype none
`include "bpf_defs.svh"

module bpf_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        flush,
    input  logic                        fetch_vld,
    input  logic [`BPF_CODE_ADDR_W-1:0] fetch_pc,
    input  logic [`BPF_INSTR_W-1:0]     instr_in,
    output logic                        dec_vld,
    output logic [`BPF_CODE_ADDR_W-1:0] dec_pc,
    output bpf_pkg::bpf_op_e            dec_op,
    output bpf_pkg::bpf_alu_e           dec_alu,
    output bpf_pkg::bpf_jmp_e           dec_jmp,
    output logic                        dec_src_x,
    output bpf_pkg::bpf_size_e          dec_size,
    output logic [31:0]                 dec_k,
    output logic [7:0]                  dec_jt,
    output logic [7:0]                  dec_jf
);

    logic [15:0]      opc;
    logic [7:0]       code;
    logic             size_w;
    bpf_pkg::bpf_op_e op_d;

    assign opc    = instr_in[63:48];
    assign code   = opc[7:0];
    assign size_w = (code[4:3] == 2'h0);

    // Mode field is bits 7:5: imm 0, abs 1, ind 2, mem 3, len 4
    always_comb begin
        op_d = bpf_pkg::OP_ILLEGAL;
        if (opc[15:8] == 8'h00) begin
            case (bpf_pkg::bpf_class_e'(code[2:0]))
                bpf_pkg::CLS_LD: begin
                    case (code[7:5])
                        3'h0: if (size_w) op_d = bpf_pkg::OP_LD_IMM;
                        3'h1: if (code[4:3] != 2'h3) op_d = bpf_pkg::OP_LD_ABS;
                        3'h2: if (code[4:3] != 2'h3) op_d = bpf_pkg::OP_LD_IND;
                        3'h3: if (size_w) op_d = bpf_pkg::OP_LD_MEM;
                        3'h4: if (size_w) op_d = bpf_pkg::OP_LD_LEN;
                        default: ;
                    endcase
                end
                bpf_pkg::CLS_LDX: begin
                    case (code[7:5])
                        3'h0: if (size_w) op_d = bpf_pkg::OP_LDX_IMM;
                        3'h3: if (size_w) op_d = bpf_pkg::OP_LDX_MEM;
                        3'h4: if (size_w) op_d = bpf_pkg::OP_LDX_LEN;
                        default: ;
                    endcase
                end
                bpf_pkg::CLS_ST:  if (code[7:3] == '0) op_d = bpf_pkg::OP_ST;
                bpf_pkg::CLS_STX: if (code[7:3] == '0) op_d = bpf_pkg::OP_STX;
                bpf_pkg::CLS_ALU: begin
                    case (bpf_pkg::bpf_alu_e'(code[7:4]))
                        bpf_pkg::ALU_ADD, bpf_pkg::ALU_SUB, bpf_pkg::ALU_AND,
                        bpf_pkg::ALU_OR, bpf_pkg::ALU_LSH, bpf_pkg::ALU_RSH:
                            op_d = bpf_pkg::OP_ALU;
                        default: ;
                    endcase
                end
                bpf_pkg::CLS_JMP: begin
                    // Only K-operand jumps
                    if (!code[7] && !code[3]) begin
                        case (bpf_pkg::bpf_jmp_e'(code[6:4]))
                            bpf_pkg::JMP_JA: op_d = bpf_pkg::OP_JA;
                            bpf_pkg::JMP_JEQ, bpf_pkg::JMP_JGT,
                            bpf_pkg::JMP_JGE, bpf_pkg::JMP_JSET:
                                op_d = bpf_pkg::OP_JCOND;
                            default: ;
                        endcase
                    end
                end
                bpf_pkg::CLS_RET: begin
                    if (code[7:3] == 5'h00) op_d = bpf_pkg::OP_RET_K;
                    if (code[7:3] == 5'h02) op_d = bpf_pkg::OP_RET_A;
                end
                bpf_pkg::CLS_MISC: begin
                    if (code == 8'h07) op_d = bpf_pkg::OP_TAX;
                    if (code == 8'h87) op_d = bpf_pkg::OP_TXA;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_vld <= 1'b0;
        end else if (!stall) begin
            dec_vld <= fetch_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_pc    <= fetch_pc;
            dec_op    <= op_d;
            dec_alu   <= bpf_pkg::bpf_alu_e'(code[7:4]);
            dec_jmp   <= bpf_pkg::bpf_jmp_e'(code[6:4]);
            dec_src_x <= code[3];
            dec_size  <= bpf_pkg::bpf_size_e'(code[4:3]);
            dec_jt    <= instr_in[47:40];
            dec_jf    <= instr_in[39:32];
            dec_k     <= instr_in[31:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpf_execute.sv
`default_nettype none
`include "bpf_defs.svh"

module bpf_execute (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dec_vld,
    input  logic [`BPF_CODE_ADDR_W-1:0] dec_pc,
    input  bpf_pkg::bpf_op_e            dec_op,
    input  bpf_pkg::bpf_alu_e           dec_alu,
    input  bpf_pkg::bpf_jmp_e           dec_jmp,
    input  logic                        dec_src_x,
    input  bpf_pkg::bpf_size_e          dec_size,
    input  logic [31:0]                 dec_k,
    input  logic [7:0]                  dec_jt,
    input  logic [7:0]                  dec_jf,
    input  logic [`BPF_PLEN_W-1:0]      packet_len,
    input  logic [31:0]                 mem_data,
    input  logic                        mem_vld,
    output logic [`BPF_BYTE_ADDR_W-1:0] byte_rd_addr,
    output logic                        rd_en,
    output bpf_pkg::bpf_size_e          transfer_sz,
    output logic                        acc,
    output logic                        rej,
    output logic                        stall,
    output logic                        redirect,
    output logic [`BPF_CODE_ADDR_W-1:0] redirect_pc
);

    logic [31:0]                 a_q;
    logic [31:0]                 x_q;
    logic [31:0]                 scratch_q [`BPF_SCRATCH_N];
    logic                        wait_q;
    logic                        go;
    logic                        pkt_ld;
    logic                        in_bounds;
    logic [2:0]                  ld_bytes;
    logic [32:0]                 ld_addr;
    logic [33:0]                 ld_end;
    logic [31:0]                 alu_b;
    logic [31:0]                 alu_res;
    logic                        cond;
    logic [`BPF_CODE_ADDR_W-1:0] jmp_off;
    logic [31:0]                 ret_val;
    logic                        retire;
    logic                        fault;

    // Nothing executes once a result is held
    assign go     = dec_vld && !(acc || rej);
    assign pkt_ld = (dec_op == bpf_pkg::OP_LD_ABS) || (dec_op == bpf_pkg::OP_LD_IND);

    // Packet address and bounds check
    always_comb begin
        case (dec_size)
            bpf_pkg::SZ_B: ld_bytes = 3'd1;
            bpf_pkg::SZ_H: ld_bytes = 3'd2;
            default:       ld_bytes = 3'd4;
        endcase
    end

    assign ld_addr   = {1'b0, dec_k} + ((dec_op == bpf_pkg::OP_LD_IND) ? {1'b0, x_q} : 33'd0);
    assign ld_end    = {1'b0, ld_addr} + 34'(ld_bytes);
    assign in_bounds = (ld_end <= 34'(packet_len));

    assign byte_rd_addr = ld_addr[`BPF_BYTE_ADDR_W-1:0];
    assign transfer_sz  = dec_size;
    assign rd_en        = go && pkt_ld && in_bounds && !wait_q;

    // Load holds the pipe until its data returns
    assign stall = acc || rej || (go && pkt_ld && in_bounds && !(wait_q && mem_vld));

    assign alu_b = dec_src_x ? x_q : dec_k;

    always_comb begin
        case (dec_alu)
            bpf_pkg::ALU_ADD: alu_res = a_q + alu_b;
            bpf_pkg::ALU_SUB: alu_res = a_q - alu_b;
            bpf_pkg::ALU_AND: alu_res = a_q & alu_b;
            bpf_pkg::ALU_OR:  alu_res = a_q | alu_b;
            bpf_pkg::ALU_LSH: alu_res = a_q << alu_b;
            bpf_pkg::ALU_RSH: alu_res = a_q >> alu_b;
            default:          alu_res = a_q;
        endcase
    end

    always_comb begin
        case (dec_jmp)
            bpf_pkg::JMP_JEQ:  cond = (a_q == dec_k);
            bpf_pkg::JMP_JGT:  cond = (a_q > dec_k);
            bpf_pkg::JMP_JGE:  cond = (a_q >= dec_k);
            bpf_pkg::JMP_JSET: cond = ((a_q & dec_k) != '0);
            default:           cond = 1'b0;
        endcase
    end

    // JA jumps by k, conditional jumps by jt or jf
    assign jmp_off = (dec_op == bpf_pkg::OP_JA) ? dec_k[`BPF_CODE_ADDR_W-1:0] :
                     `BPF_CODE_ADDR_W'(cond ? dec_jt : dec_jf);

    // Zero offset falls through without a redirect
    assign redirect    = go && ((dec_op == bpf_pkg::OP_JA) || (dec_op == bpf_pkg::OP_JCOND))
                         && (jmp_off != '0);
    assign redirect_pc = dec_pc + 1'b1 + jmp_off;

    assign ret_val = (dec_op == bpf_pkg::OP_RET_A) ? a_q : dec_k;
    assign retire  = go && ((dec_op == bpf_pkg::OP_RET_K) || (dec_op == bpf_pkg::OP_RET_A));
    assign fault   = go && ((dec_op == bpf_pkg::OP_ILLEGAL) || (pkt_ld && !in_bounds));

    always_ff @(posedge clk) begin
        if (rst) begin
            a_q    <= '0;
            x_q    <= '0;
            wait_q <= 1'b0;
            acc    <= 1'b0;
            rej    <= 1'b0;
            for (int i = 0; i < `BPF_SCRATCH_N; i++) begin
                scratch_q[i] <= '0;
            end
        end else begin
            if (rd_en) begin
                wait_q <= 1'b1;
            end else if (wait_q && mem_vld) begin
                wait_q <= 1'b0;
            end

            if (retire) begin
                acc <= (ret_val != '0);
                rej <= (ret_val == '0);
            end else if (fault) begin
                rej <= 1'b1;
            end

            if (go) begin
                case (dec_op)
                    bpf_pkg::OP_LD_IMM:  a_q <= dec_k;
                    bpf_pkg::OP_LD_LEN:  a_q <= packet_len;
                    bpf_pkg::OP_LD_MEM:  a_q <= scratch_q[dec_k[$clog2(`BPF_SCRATCH_N)-1:0]];
                    bpf_pkg::OP_LD_ABS,
                    bpf_pkg::OP_LD_IND:  if (wait_q && mem_vld) a_q <= mem_data;
                    bpf_pkg::OP_LDX_IMM: x_q <= dec_k;
                    bpf_pkg::OP_LDX_LEN: x_q <= packet_len;
                    bpf_pkg::OP_LDX_MEM: x_q <= scratch_q[dec_k[$clog2(`BPF_SCRATCH_N)-1:0]];
                    bpf_pkg::OP_ST:      scratch_q[dec_k[$clog2(`BPF_SCRATCH_N)-1:0]] <= a_q;
                    bpf_pkg::OP_STX:     scratch_q[dec_k[$clog2(`BPF_SCRATCH_N)-1:0]] <= x_q;
                    bpf_pkg::OP_ALU:     a_q <= alu_res;
                    bpf_pkg::OP_TAX:     x_q <= a_q;
                    bpf_pkg::OP_TXA:     a_q <= x_q;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpf_cpu.sv
`default_nettype none
`include "bpf_defs.svh"

module bpf_cpu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy_for_cpu,
    output logic                        rdy_for_cpu_ack,
    input  logic                        cpu_done_ack,
    input  logic [`BPF_PLEN_W-1:0]      cpu_byte_len,
    output logic [`BPF_BYTE_ADDR_W-1:0] byte_rd_addr,
    output logic                        cpu_rd_en,
    output bpf_pkg::bpf_size_e          transfer_sz,
    input  logic [31:0]                 resized_mem_data,
    input  logic                        resized_mem_data_vld,
    output logic                        cpu_acc,
    output logic                        cpu_rej,
    output logic [`BPF_CODE_ADDR_W-1:0] inst_rd_addr,
    output logic                        inst_rd_en,
    input  logic [`BPF_INSTR_W-1:0]     instr_in
);

    bpf_pkg::bpf_run_e           state;
    logic                        core_rst;
    logic                        stall;
    logic                        redirect;
    logic [`BPF_CODE_ADDR_W-1:0] redirect_pc;
    logic                        fetch_vld;
    logic [`BPF_CODE_ADDR_W-1:0] fetch_pc;
    logic                        dec_vld;
    logic [`BPF_CODE_ADDR_W-1:0] dec_pc;
    bpf_pkg::bpf_op_e            dec_op;
    bpf_pkg::bpf_alu_e           dec_alu;
    bpf_pkg::bpf_jmp_e           dec_jmp;
    logic                        dec_src_x;
    bpf_pkg::bpf_size_e          dec_size;
    logic [31:0]                 dec_k;
    logic [7:0]                  dec_jt;
    logic [7:0]                  dec_jf;

    // Engine handshake, start on ready and ack, stop on result and ack
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bpf_pkg::STOPPED;
        end else if (state == bpf_pkg::STOPPED) begin
            if (rdy_for_cpu && rdy_for_cpu_ack) state <= bpf_pkg::STARTED;
        end else if ((cpu_acc || cpu_rej) && cpu_done_ack) begin
            state <= bpf_pkg::STOPPED;
        end
    end

    assign rdy_for_cpu_ack = (state == bpf_pkg::STOPPED);

    // Core sits in reset between packets
    assign core_rst = rst || (state == bpf_pkg::STOPPED);

    bpf_fetch u_fetch (
        .clk(clk), .rst(core_rst), .stall(stall),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .inst_rd_addr(inst_rd_addr), .inst_rd_en(inst_rd_en),
        .fetch_vld(fetch_vld), .fetch_pc(fetch_pc)
    );

    bpf_decode u_decode (
        .clk(clk), .rst(core_rst), .stall(stall), .flush(redirect),
        .fetch_vld(fetch_vld), .fetch_pc(fetch_pc), .instr_in(instr_in),
        .dec_vld(dec_vld), .dec_pc(dec_pc), .dec_op(dec_op), .dec_alu(dec_alu),
        .dec_jmp(dec_jmp), .dec_src_x(dec_src_x), .dec_size(dec_size),
        .dec_k(dec_k), .dec_jt(dec_jt), .dec_jf(dec_jf)
    );

    bpf_execute u_execute (
        .clk(clk), .rst(core_rst),
        .dec_vld(dec_vld), .dec_pc(dec_pc), .dec_op(dec_op), .dec_alu(dec_alu),
        .dec_jmp(dec_jmp), .dec_src_x(dec_src_x), .dec_size(dec_size),
        .dec_k(dec_k), .dec_jt(dec_jt), .dec_jf(dec_jf),
        .packet_len(cpu_byte_len), .mem_data(resized_mem_data),
        .mem_vld(resized_mem_data_vld),
        .byte_rd_addr(byte_rd_addr), .rd_en(cpu_rd_en), .transfer_sz(transfer_sz),
        .acc(cpu_acc), .rej(cpu_rej), .stall(stall),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire

//--- dv/bpf_tb_mem.sv
`default_nettype none
`include "bpf_defs.svh"

module bpf_tb_mem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`BPF_CODE_ADDR_W-1:0] inst_rd_addr,
    input  logic                        inst_rd_en,
    output logic [`BPF_INSTR_W-1:0]     instr_in,
    input  logic [`BPF_BYTE_ADDR_W-1:0] byte_rd_addr,
    input  logic                        cpu_rd_en,
    input  bpf_pkg::bpf_size_e          transfer_sz,
    output logic [31:0]                 resized_mem_data,
    output logic                        resized_mem_data_vld
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`BPF_INSTR_W-1:0]     rom [1 << `BPF_CODE_ADDR_W];
    logic [7:0]                  pkt [1 << `BPF_BYTE_ADDR_W];
    logic [`BPF_BYTE_ADDR_W-1:0] rd_addr_q;
    bpf_pkg::bpf_size_e          rd_sz_q;
    logic [2:0]                  wait_cnt;

    // Big-endian bytes, right-justified and zero-extended
    function automatic logic [31:0] read_bytes(input logic [`BPF_BYTE_ADDR_W-1:0] a,
                                               input bpf_pkg::bpf_size_e sz);
        case (sz)
            bpf_pkg::SZ_B: return {24'h0, pkt[a]};
            bpf_pkg::SZ_H: return {16'h0, pkt[a], pkt[a + 12'd1]};
            default:       return {pkt[a], pkt[a + 12'd1], pkt[a + 12'd2], pkt[a + 12'd3]};
        endcase
    endfunction

    initial begin
        for (int i = 0; i < (1 << `BPF_CODE_ADDR_W); i++) begin
            // Opcode ffff never decodes, low bits carry the word address
            rom[i] = {16'hffff, 38'h0, 10'(i)};
        end
        for (int i = 0; i < (1 << `BPF_BYTE_ADDR_W); i++) begin
            pkt[i] = 8'(i ^ (i >> 8));
        end
    end

    // Instruction ROM, word valid one cycle after the read
    always_ff @(posedge clk) begin
        if (inst_rd_en) begin
            instr_in <= rom[inst_rd_addr];
        end
    end

    // Packet port, random latency per read
    always_ff @(posedge clk) begin
        resized_mem_data_vld <= 1'b0;
        if (rst) begin
            wait_cnt         <= '0;
            resized_mem_data <= '0;
        end else if (cpu_rd_en) begin
            rd_addr_q <= byte_rd_addr;
            rd_sz_q   <= transfer_sz;
            wait_cnt  <= 3'(($urandom % 4) + 1);
        end else if (wait_cnt != 3'd0) begin
            wait_cnt <= wait_cnt - 3'd1;
            if (wait_cnt == 3'd1) begin
                resized_mem_data_vld <= 1'b1;
                resized_mem_data     <= read_bytes(rd_addr_q, rd_sz_q);
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/bpf_cpu_tb.sv
`default_nettype none
`include "bpf_defs.svh"

module bpf_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Ten back-to-back packets are the longest test, each well under 300 cycles
    localparam int MAX_CYCLES = 20000;

    // Addressing modes, opcode bits 7:5
    localparam int M_IMM = 0;
    localparam int M_ABS = 1;
    localparam int M_IND = 2;
    localparam int M_MEM = 3;
    localparam int M_LEN = 4;

    logic                        clk;
    logic                        rst;
    logic                        rdy_for_cpu;
    logic                        rdy_for_cpu_ack;
    logic                        cpu_done_ack;
    logic [`BPF_PLEN_W-1:0]      cpu_byte_len;
    logic [`BPF_BYTE_ADDR_W-1:0] byte_rd_addr;
    logic                        cpu_rd_en;
    bpf_pkg::bpf_size_e          transfer_sz;
    logic [31:0]                 resized_mem_data;
    logic                        resized_mem_data_vld;
    logic                        cpu_acc;
    logic                        cpu_rej;
    logic [`BPF_CODE_ADDR_W-1:0] inst_rd_addr;
    logic                        inst_rd_en;
    logic [`BPF_INSTR_W-1:0]     instr_in;

    int                          cycles;
    int                          errors;
    int                          checks;
    int                          tests;
    int                          prog_len;
    int                          rd_count;
    logic [`BPF_BYTE_ADDR_W-1:0] rd_addr_seen;
    bpf_pkg::bpf_size_e          rd_sz_seen;

    bpf_cpu u_bpf_cpu (.*);

    bpf_tb_mem u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the DUT gave no result within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("Test %s done with %0d errors", name, errors - err0);
    endtask

    function automatic logic [63:0] insn(input logic [15:0] code, input logic [7:0] jt,
                                         input logic [7:0] jf, input logic [31:0] k);
        return {code, jt, jf, k};
    endfunction

    // Class in bits 2:0, size in 4:3, mode in 7:5
    function automatic logic [15:0] ld_code(input bpf_pkg::bpf_class_e cls,
                                            input bpf_pkg::bpf_size_e sz, input int mode);
        return 16'(cls) | (16'(sz) << 3) | 16'(mode << 5);
    endfunction

    function automatic logic [15:0] alu_code(input bpf_pkg::bpf_alu_e op, input logic src_x);
        return 16'(bpf_pkg::CLS_ALU) | (16'(op) << 4) | (src_x ? 16'h8 : 16'h0);
    endfunction

    function automatic logic [15:0] jmp_code(input bpf_pkg::bpf_jmp_e j);
        return 16'(bpf_pkg::CLS_JMP) | (16'(j) << 4);
    endfunction

    function automatic logic [15:0] ret_code(input logic ret_a);
        return 16'(bpf_pkg::CLS_RET) | (ret_a ? 16'h10 : 16'h0);
    endfunction

    task automatic emit(input logic [63:0] w);
        u_mem.rom[prog_len] = w;
        prog_len++;
    endtask

    // One packet through start, result and done ack
    task automatic run_packet(input int ack_delay, output logic acc);
        logic                        res_acc;
        logic                        res_rej;
        logic                        fetch_seen;
        logic [`BPF_CODE_ADDR_W-1:0] fetch_addr;
        rd_count = 0;
        fetch_seen = 1'b0;
        fetch_addr = '1;
        rdy_for_cpu = 1'b1;
        @(negedge clk);
        while (rdy_for_cpu_ack) begin
            @(negedge clk);
        end
        rdy_for_cpu = 1'b0;
        while (!(cpu_acc || cpu_rej)) begin
            if (inst_rd_en && !fetch_seen) begin
                fetch_seen = 1'b1;
                fetch_addr = inst_rd_addr;
            end
            if (cpu_rd_en) begin
                rd_count++;
                rd_addr_seen = byte_rd_addr;
                rd_sz_seen   = transfer_sz;
            end
            @(negedge clk);
        end
        res_acc = cpu_acc;
        res_rej = cpu_rej;
        // Every program starts from PC 0
        compare("inst_rd_addr", 32'(fetch_addr), 32'd0);
        compare("cpu_acc^cpu_rej", 32'(cpu_acc ^ cpu_rej), 32'd1);
        // Result must hold until the engine acks
        for (int i = 0; i < ack_delay; i++) begin
            @(negedge clk);
            compare("cpu_acc", 32'(cpu_acc), 32'(res_acc));
            compare("cpu_rej", 32'(cpu_rej), 32'(res_rej));
            compare("rdy_for_cpu_ack", 32'(rdy_for_cpu_ack), 32'd0);
        end
        cpu_done_ack = 1'b1;
        @(negedge clk);
        cpu_done_ack = 1'b0;
        compare("rdy_for_cpu_ack", 32'(rdy_for_cpu_ack), 32'd1);
        @(negedge clk);
        compare("cpu_acc", 32'(cpu_acc), 32'd0);
        compare("cpu_rej", 32'(cpu_rej), 32'd0);
        acc = res_acc;
    endtask

    task automatic load_ethertype();
        prog_len = 0;
        emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_H, M_ABS), 8'd0, 8'd0, 32'd12));
        emit(insn(jmp_code(bpf_pkg::JMP_JEQ), 8'd0, 8'd1, 32'h0800));
        emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd96));
        emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd0));
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        for (int i = 0; i < 10; i++) begin
            compare("rdy_for_cpu_ack", 32'(rdy_for_cpu_ack), 32'd1);
            compare("inst_rd_en", 32'(inst_rd_en), 32'd0);
            compare("cpu_rd_en", 32'(cpu_rd_en), 32'd0);
            compare("cpu_acc", 32'(cpu_acc), 32'd0);
            compare("cpu_rej", 32'(cpu_rej), 32'd0);
            @(negedge clk);
        end
        report_test("reset_state", err0);
    endtask

    task automatic ethertype_filter();
        int   err0;
        logic acc;
        err0 = errors;
        load_ethertype();
        cpu_byte_len = 64;
        u_mem.pkt[12] = 8'h08;
        u_mem.pkt[13] = 8'h00;
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd1);
        compare("cpu_rd_en pulses", rd_count, 32'd1);
        compare("byte_rd_addr", 32'(rd_addr_seen), 32'd12);
        compare("transfer_sz", 32'(rd_sz_seen), 32'(bpf_pkg::SZ_H));
        u_mem.pkt[12] = 8'h86;
        u_mem.pkt[13] = 8'hdd;
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd0);
        report_test("ethertype_filter", err0);
    endtask

    task automatic alu_scratch();
        int          err0;
        logic        acc;
        logic [31:0] k1;
        logic [31:0] k2;
        logic [31:0] k3;
        logic [31:0] c;
        err0 = errors;
        k1 = $urandom;
        k2 = $urandom;
        k3 = $urandom % 32;
        c  = ((k1 + k2) & k1) << k3;
        for (int pass = 0; pass < 2; pass++) begin
            prog_len = 0;
            emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_W, M_IMM), 8'd0, 8'd0, k1));
            emit(insn(16'h0007, 8'd0, 8'd0, 32'd0));
            emit(insn(alu_code(bpf_pkg::ALU_ADD, 1'b0), 8'd0, 8'd0, k2));
            emit(insn(alu_code(bpf_pkg::ALU_AND, 1'b1), 8'd0, 8'd0, 32'd0));
            emit(insn(16'(bpf_pkg::CLS_ST), 8'd0, 8'd0, 32'd7));
            // Clobber A so the value must come back through M[7] and X
            emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_W, M_IMM), 8'd0, 8'd0, 32'd0));
            emit(insn(ld_code(bpf_pkg::CLS_LDX, bpf_pkg::SZ_W, M_MEM), 8'd0, 8'd0, 32'd7));
            emit(insn(16'h0087, 8'd0, 8'd0, 32'd0));
            emit(insn(alu_code(bpf_pkg::ALU_LSH, 1'b0), 8'd0, 8'd0, k3));
            emit(insn(jmp_code(bpf_pkg::JMP_JEQ), 8'd0, 8'd1, c + 32'(pass)));
            emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd1));
            emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd0));
            run_packet(0, acc);
            compare("cpu_acc", 32'(acc), (pass == 0) ? 32'd1 : 32'd0);
        end
        report_test("alu_scratch", err0);
    endtask

    task automatic length_bounds();
        int   err0;
        logic acc;
        err0 = errors;
        prog_len = 0;
        emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_W, M_LEN), 8'd0, 8'd0, 32'd0));
        emit(insn(ret_code(1'b1), 8'd0, 8'd0, 32'd0));
        cpu_byte_len = 64;
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd1);
        cpu_byte_len = 0;
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd0);
        // Word at len-3 runs one byte past the end
        cpu_byte_len = 64;
        prog_len = 0;
        emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_W, M_ABS), 8'd0, 8'd0, 32'd61));
        emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd1));
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd0);
        compare("cpu_rd_en pulses", rd_count, 32'd0);
        u_mem.pkt[60] = 8'hde;
        u_mem.pkt[61] = 8'had;
        u_mem.pkt[62] = 8'hbe;
        u_mem.pkt[63] = 8'hef;
        prog_len = 0;
        emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_W, M_ABS), 8'd0, 8'd0, 32'd60));
        emit(insn(jmp_code(bpf_pkg::JMP_JEQ), 8'd0, 8'd1, 32'hdeadbeef));
        emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd1));
        emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd0));
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd1);
        compare("cpu_rd_en pulses", rd_count, 32'd1);
        compare("byte_rd_addr", 32'(rd_addr_seen), 32'd60);
        compare("transfer_sz", 32'(rd_sz_seen), 32'(bpf_pkg::SZ_W));
        report_test("length_bounds", err0);
    endtask

    task automatic held_result();
        int   err0;
        logic acc;
        err0 = errors;
        load_ethertype();
        cpu_byte_len = 64;
        for (int i = 0; i < 10; i++) begin
            u_mem.pkt[12] = (i % 2 == 0) ? 8'h08 : 8'h86;
            u_mem.pkt[13] = (i % 2 == 0) ? 8'h00 : 8'hdd;
            run_packet(int'($urandom % 11), acc);
            compare("cpu_acc", 32'(acc), (i % 2 == 0) ? 32'd1 : 32'd0);
        end
        report_test("held_result", err0);
    endtask

    task automatic unknown_opcode();
        int   err0;
        logic acc;
        err0 = errors;
        cpu_byte_len = 64;
        prog_len = 0;
        // ALU multiply, not in the supported set
        emit(insn(16'h0024, 8'd0, 8'd0, 32'd3));
        // Load behind it must never reach the packet port
        emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_H, M_ABS), 8'd0, 8'd0, 32'd12));
        emit(insn(ret_code(1'b0), 8'd0, 8'd0, 32'd1));
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd0);
        compare("cpu_rd_en pulses", rd_count, 32'd0);
        u_mem.pkt[12] = 8'h08;
        u_mem.pkt[13] = 8'h00;
        u_mem.pkt[14] = 8'h45;
        u_mem.pkt[15] = 8'h00;
        prog_len = 0;
        emit(insn(ld_code(bpf_pkg::CLS_LDX, bpf_pkg::SZ_W, M_IMM), 8'd0, 8'd0, 32'd10));
        emit(insn(ld_code(bpf_pkg::CLS_LD, bpf_pkg::SZ_W, M_IND), 8'd0, 8'd0, 32'd2));
        emit(insn(ret_code(1'b1), 8'd0, 8'd0, 32'd0));
        run_packet(0, acc);
        compare("cpu_acc", 32'(acc), 32'd1);
        compare("cpu_rd_en pulses", rd_count, 32'd1);
        compare("byte_rd_addr", 32'(rd_addr_seen), 32'd12);
        compare("transfer_sz", 32'(rd_sz_seen), 32'(bpf_pkg::SZ_W));
        report_test("unknown_opcode", err0);
    endtask

    initial begin
        void'($urandom(32'h948b));
        errors       = 0;
        checks       = 0;
        tests        = 0;
        rst          = 1'b1;
        rdy_for_cpu  = 1'b0;
        cpu_done_ack = 1'b0;
        cpu_byte_len = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        reset_state();
        ethertype_filter();
        alu_scratch();
        length_bounds();
        held_result();
        unknown_opcode();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/bpf_pkg.sv
rtl/bpf_fetch.sv
rtl/bpf_decode.sv
rtl/bpf_execute.sv
rtl/bpf_cpu.sv
dv/bpf_tb_mem.sv
dv/bpf_cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the BPF CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module bpf_cpu_tb -f vlog.f -o sim_bpf_cpu

./obj_dir/sim_bpf_cpu > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
